// File: Makefile
# Verilator simulation of the fetch-to-issue frontend
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# Build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/elastic_buffer.sv
// Two-entry valid/ready pipeline register with a registered ready output
// One cycle latency, one word per cycle when the output is never stalled
`timescale 1ns/1ps

module elastic_buffer #(
    parameter int DW = 32
) (
    input  logic          clk,
    input  logic          rst_n,
    // Upstream side
    input  logic [DW-1:0] data_i,
    input  logic          valid_i,
    output logic          ready_o,
    // Downstream side
    output logic [DW-1:0] data_o,
    output logic          valid_o,
    input  logic          ready_i
);

    logic [DW-1:0] main_data;
    logic          main_valid;
    logic [DW-1:0] skid_data;
    logic          skid_valid;
    logic          ready_q;

    logic          in_fire;
    logic          main_free;
    logic          main_valid_nxt;
    logic          skid_valid_nxt;

    assign in_fire = valid_i & ready_q;

    // Main entry can take a word when empty or being drained this cycle
    assign main_free = ~main_valid | ready_i;

    //////////////////////////////////////////////////////////////////////
    // Next-state control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        main_valid_nxt = main_valid;
        skid_valid_nxt = skid_valid;
        if (main_free) begin
            // Parked word has priority, input is blocked while it waits
            if (skid_valid) begin
                main_valid_nxt = 1'b1;
                skid_valid_nxt = 1'b0;
            end else begin
                main_valid_nxt = in_fire;
            end
        end else if (in_fire) begin
            skid_valid_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b0;
        end else begin
            main_valid <= main_valid_nxt;
            skid_valid <= skid_valid_nxt;
            // Ready falls only once both entries hold a word
            ready_q    <= ~skid_valid_nxt;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (main_free) begin
            main_data <= skid_valid ? skid_data : data_i;
        end
        if (!main_free && in_fire) begin
            skid_data <= data_i;
        end
    end

    assign data_o  = main_data;
    assign valid_o = main_valid;
    assign ready_o = ready_q;

endmodule

// File: logic/frontend_defs.svh
// Width and depth constants for the fetch-to-issue frontend
// FE_QUEUE_DEPTH must be a power of two and at least 2
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Program counter width
`define FE_PC_BITS 32

// One instruction word
`define FE_INSTR_BITS 32

//////////////////////////////////////////////////////////////////////
// Instruction queue
//////////////////////////////////////////////////////////////////////

// Entries in the instruction queue, power of two
`define FE_QUEUE_DEPTH 4

`endif

// File: logic/frontend_pkg.sv
// Types shared by the frontend blocks
// A fetch pair is two packets, packet_a in the low half and issued first
`include "frontend_defs.svh"

package frontend_pkg;

    //////////////////////////////////////////////////////////////////////
    // Single fetched instruction
    //////////////////////////////////////////////////////////////////////

    // Valid sits at the top, data at the bottom
    typedef struct packed {
        logic                      valid;
        logic                      taken_branch;
        logic [`FE_PC_BITS-1:0]    pc;
        logic [`FE_INSTR_BITS-1:0] data;
    } fetch_packet_t;

    //////////////////////////////////////////////////////////////////////
    // Fetch pair
    //////////////////////////////////////////////////////////////////////

    // Pipeline registers move the flat bits,
    // the instruction queue splits the word into its two packets
    typedef union packed {
        logic [2*$bits(fetch_packet_t)-1:0] raw;
        struct packed {
            fetch_packet_t packet_b;
            fetch_packet_t packet_a;
        } pair;
    } fetch_pair_u;

endpackage

// File: logic/frontend_top.sv
// Fetch-to-issue path: IF/ID elastic register feeding the instruction queue
// Flush clears the queue only, a pair held in the IF/ID register survives it
`timescale 1ns/1ps
`include "frontend_defs.svh"

module frontend_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // Fetch side
    input  logic                        fetch_valid_i,
    input  frontend_pkg::fetch_pair_u   fetch_pair_i,
    output logic                        fetch_ready_o,
    // Control from issue
    input  logic                        flush_i,
    input  logic                        pop_1_i,
    input  logic                        pop_2_i,
    // Issue slots
    output logic                        slot_1_valid_o,
    output logic                        slot_2_valid_o,
    output frontend_pkg::fetch_packet_t slot_1_o,
    output frontend_pkg::fetch_packet_t slot_2_o
);

    import frontend_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // IF/ID pipeline register
    //////////////////////////////////////////////////////////////////////

    fetch_pair_u if_id_pair;
    logic        if_id_valid;
    logic        iq_ready;

    // Carries the pair as flat bits
    elastic_buffer #(
        .DW (2*$bits(fetch_packet_t))
    ) if_id_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .data_i  (fetch_pair_i.raw),
        .valid_i (fetch_valid_i),
        .ready_o (fetch_ready_o),
        .data_o  (if_id_pair),
        .valid_o (if_id_valid),
        .ready_i (iq_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // Instruction queue
    //////////////////////////////////////////////////////////////////////

    instr_queue #(
        .DEPTH (`FE_QUEUE_DEPTH)
    ) instruction_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush_i),
        .push_valid_i   (if_id_valid),
        .push_pair_i    (if_id_pair),
        .push_ready_o   (iq_ready),
        .pop_1_i        (pop_1_i),
        .pop_2_i        (pop_2_i),
        .slot_1_valid_o (slot_1_valid_o),
        .slot_2_valid_o (slot_2_valid_o),
        .slot_1_o       (slot_1_o),
        .slot_2_o       (slot_2_o)
    );

endmodule

// File: logic/instr_queue.sv
// Circular instruction queue, up to two pushes and two pops per cycle
// DEPTH must be a power of two and at least 2; flush drops every entry
`timescale 1ns/1ps

module instr_queue #(
    parameter int DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush_i,
    // Push side, one fetch pair per cycle
    input  logic                        push_valid_i,
    input  frontend_pkg::fetch_pair_u   push_pair_i,
    output logic                        push_ready_o,
    // Pop side, head entry and the one behind it
    input  logic                        pop_1_i,
    input  logic                        pop_2_i,
    output logic                        slot_1_valid_o,
    output logic                        slot_2_valid_o,
    output frontend_pkg::fetch_packet_t slot_1_o,
    output frontend_pkg::fetch_packet_t slot_2_o
);

    import frontend_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_packet_t    mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic             push_fire;
    logic             wr_a;
    logic             wr_b;
    logic [PTR_W-1:0] wr_b_ptr;
    logic [1:0]       n_push;
    logic             pop_1_ok;
    logic             pop_2_ok;
    logic [1:0]       n_pop;

    //////////////////////////////////////////////////////////////////////
    // Push side
    //////////////////////////////////////////////////////////////////////

    // Room for a full pair is required, whatever its valid bits say
    assign push_ready_o = (count <= CNT_W'(DEPTH - 2)) & ~flush_i;
    assign push_fire    = push_valid_i & push_ready_o;

    assign wr_a = push_fire & push_pair_i.pair.packet_a.valid;
    assign wr_b = push_fire & push_pair_i.pair.packet_b.valid;

    // Packet_b follows packet_a, or takes the tail slot when a is empty
    assign wr_b_ptr = tail + PTR_W'(wr_a);
    assign n_push   = 2'(wr_a) + 2'(wr_b);

    always_ff @(posedge clk) begin
        if (wr_a) begin
            mem[tail] <= push_pair_i.pair.packet_a;
        end
        if (wr_b) begin
            mem[wr_b_ptr] <= push_pair_i.pair.packet_b;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pop side
    //////////////////////////////////////////////////////////////////////

    assign slot_1_valid_o = (count != '0);
    assign slot_2_valid_o = (count >= CNT_W'(2));

    // Read straight from storage, pointer wraps by width
    assign slot_1_o = mem[head];
    assign slot_2_o = mem[head + PTR_W'(1)];

    // Second pop only counts together with the first one
    assign pop_1_ok = pop_1_i & slot_1_valid_o;
    assign pop_2_ok = pop_1_ok & pop_2_i & slot_2_valid_o;
    assign n_pop    = 2'(pop_1_ok) + 2'(pop_2_ok);

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            // No push can land here, ready is already low
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_W'(n_pop);
            tail  <= tail + PTR_W'(n_push);
            count <= count + CNT_W'(n_push) - CNT_W'(n_pop);
        end
    end

endmodule

// File: sim.f
+incdir+logic
logic/frontend_pkg.sv
logic/elastic_buffer.sv
logic/instr_queue.sv
logic/frontend_top.sv
verification/frontend_checker.sv
verification/frontend_tb.sv

// File: verification/frontend_checker.sv
// Reference model of the IF/ID buffer and instruction queue, checked every cycle
// Model updates on the rising edge and DUT outputs are compared on the falling edge
`timescale 1ns/1ps
`include "frontend_defs.svh"

module frontend_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    // Fetch handshake as seen at the DUT pins
    input  logic                        fetch_valid_i,
    input  frontend_pkg::fetch_pair_u   fetch_pair_i,
    input  logic                        fetch_ready_i,
    // Issue side controls
    input  logic                        flush_i,
    input  logic                        pop_1_i,
    input  logic                        pop_2_i,
    // Issue slots driven by the DUT
    input  logic                        slot_1_valid_i,
    input  logic                        slot_2_valid_i,
    input  frontend_pkg::fetch_packet_t slot_1_i,
    input  frontend_pkg::fetch_packet_t slot_2_i,
    input  int                          test_num_i,
    output int                          error_count_o,
    output int                          check_count_o
);

    import frontend_pkg::*;

    localparam int DEPTH = `FE_QUEUE_DEPTH;

    fetch_pair_u   held_q[$];
    fetch_packet_t ref_q[$];
    logic          ready_m;
    logic          started;
    int            errors_at_start;
    int            last_test;

    initial begin
        error_count_o   = 0;
        check_count_o   = 0;
        errors_at_start = 0;
        last_test       = 0;
        started         = 1'b0;
        ready_m         = 1'b0;
    end

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        check_count_o++;
        if (actual !== expected) begin
            error_count_o++;
            $display("** Error: %s expected 0x%h, actual 0x%h (test %0d, %0t)",
                     name, expected, actual, last_test, $time);
        end
    endtask

    task automatic compare_packet(input string name, input fetch_packet_t expected,
                                  input fetch_packet_t actual);
        check_count_o++;
        if (actual !== expected) begin
            error_count_o++;
            $display("** Error: %s expected 0x%h, actual 0x%h (test %0d, %0t)",
                     name, expected, actual, last_test, $time);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model, one step per rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : model_update
        fetch_pair_u moved;
        logic        take_pair;
        logic        move_pair;
        logic        second_pop;
        started = 1'b1;
        if (!rst_n) begin
            held_q.delete();
            ref_q.delete();
            ready_m = 1'b0;
        end else begin
            take_pair = fetch_valid_i & ready_m;
            // Queue takes a pair only with room for both packets
            move_pair = (held_q.size() > 0) && (ref_q.size() <= DEPTH - 2) && !flush_i;
            if (flush_i) begin
                ref_q.delete();
            end else if (pop_1_i && ref_q.size() >= 1) begin
                second_pop = pop_2_i && ref_q.size() >= 2;
                void'(ref_q.pop_front());
                if (second_pop) begin
                    void'(ref_q.pop_front());
                end
            end
            // Packet a first, invalid packets leave no gap
            if (move_pair) begin
                moved = held_q.pop_front();
                if (moved.pair.packet_a.valid) begin
                    ref_q.push_back(moved.pair.packet_a);
                end
                if (moved.pair.packet_b.valid) begin
                    ref_q.push_back(moved.pair.packet_b);
                end
            end
            if (take_pair) begin
                held_q.push_back(fetch_pair_i);
            end
            ready_m = held_q.size() < 2;
        end
        // Report a test once the stimulus moves on
        if (test_num_i != last_test) begin
            if (last_test != 0) begin
                $display("Test %0d finished with %0d errors", last_test,
                         error_count_o - errors_at_start);
            end
            errors_at_start = error_count_o;
            last_test       = test_num_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output comparison, mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (started) begin
            compare_bit("fetch_ready_o", ready_m, fetch_ready_i);
            compare_bit("slot_1_valid_o", ref_q.size() >= 1, slot_1_valid_i);
            compare_bit("slot_2_valid_o", ref_q.size() >= 2, slot_2_valid_i);
            if (ref_q.size() >= 1) begin
                compare_packet("slot_1_o", ref_q[0], slot_1_i);
            end
            if (ref_q.size() >= 2) begin
                compare_packet("slot_2_o", ref_q[1], slot_2_i);
            end
        end
    end

endmodule

// File: verification/frontend_tb.sv
// Table-driven testbench for the frontend, inputs change on the falling edge
// Packet contents come from a 16-bit Galois LFSR, pc steps by 4 per packet
`timescale 1ns/1ps
`include "frontend_defs.svh"

module frontend_tb;

    import frontend_pkg::*;

    localparam int HOLD_TIMEOUT  = 50;
    localparam int DRAIN_TIMEOUT = 100;

    typedef struct packed {
        logic offer;
        logic a_valid;
        logic b_valid;
        logic pop_1;
        logic pop_2;
        logic flush;
        int   reps;
        int   test;
    } row_t;

    logic                      clk;
    logic                      rst_n;
    logic                      fetch_valid;
    fetch_pair_u               fetch_pair;
    logic                      fetch_ready;
    logic                      flush;
    logic                      pop_1;
    logic                      pop_2;
    logic                      slot_1_valid;
    logic                      slot_2_valid;
    fetch_packet_t             slot_1;
    fetch_packet_t             slot_2;
    int                        test_num;
    int                        error_count;
    int                        check_count;
    int                        timeouts;
    logic [15:0]               lfsr_state;
    logic [`FE_PC_BITS-1:0]    next_pc;
    row_t                      rows[$];

    frontend_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_valid_i  (fetch_valid),
        .fetch_pair_i   (fetch_pair),
        .fetch_ready_o  (fetch_ready),
        .flush_i        (flush),
        .pop_1_i        (pop_1),
        .pop_2_i        (pop_2),
        .slot_1_valid_o (slot_1_valid),
        .slot_2_valid_o (slot_2_valid),
        .slot_1_o       (slot_1),
        .slot_2_o       (slot_2)
    );

    frontend_checker result_check (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_valid_i  (fetch_valid),
        .fetch_pair_i   (fetch_pair),
        .fetch_ready_i  (fetch_ready),
        .flush_i        (flush),
        .pop_1_i        (pop_1),
        .pop_2_i        (pop_2),
        .slot_1_valid_i (slot_1_valid),
        .slot_2_valid_i (slot_2_valid),
        .slot_1_i       (slot_1),
        .slot_2_i       (slot_2),
        .test_num_i     (test_num),
        .error_count_o  (error_count),
        .check_count_o  (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // One LFSR step per bit, taps 16,14,13,11
    function automatic logic take_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic logic [`FE_INSTR_BITS-1:0] take_word();
        logic [`FE_INSTR_BITS-1:0] word;
        word = '0;
        for (int i = 0; i < `FE_INSTR_BITS; i++) begin
            word = {word[`FE_INSTR_BITS-2:0], take_bit()};
        end
        return word;
    endfunction

    function automatic fetch_packet_t make_packet(input logic valid);
        fetch_packet_t pkt;
        pkt.valid        = valid;
        pkt.taken_branch = take_bit();
        pkt.pc           = next_pc;
        pkt.data         = take_word();
        next_pc          = next_pc + `FE_PC_BITS'(4);
        return pkt;
    endfunction

    task automatic add_row(input logic offer, input logic a_v, input logic b_v,
                           input logic p1, input logic p2, input logic fl,
                           input int reps, input int test);
        row_t r;
        r = '{offer, a_v, b_v, p1, p2, fl, reps, test};
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        int wait_cycles;
        wait_cycles = 0;
        @(negedge clk);
        test_num    = r.test;
        pop_1       = r.pop_1;
        pop_2       = r.pop_2;
        flush       = r.flush;
        fetch_valid = r.offer;
        if (r.offer) begin
            fetch_pair.pair.packet_a = make_packet(r.a_valid);
            fetch_pair.pair.packet_b = make_packet(r.b_valid);
            // Pair stays on the bus until the buffer takes it
            while (!fetch_ready && wait_cycles < HOLD_TIMEOUT) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (!fetch_ready) begin
                $display("Timeout: pair in test %0d not accepted after %0d cycles",
                         r.test, HOLD_TIMEOUT);
                timeouts++;
            end
        end
    endtask

    task automatic drain_queue();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        @(negedge clk);
        fetch_valid = 1'b0;
        flush       = 1'b0;
        pop_1       = 1'b1;
        pop_2       = 1'b1;
        while (quiet < 3 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (slot_1_valid || !fetch_ready) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        if (quiet < 3) begin
            $display("Timeout: queue did not empty within %0d cycles", DRAIN_TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic build_table();
        //      offer a     b     pop1  pop2  flush reps test
        // Reset state
        add_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2, 1);
        // Full-rate stream
        add_row(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 6, 2);
        add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 2, 2);
        // Compaction of half-valid pairs
        add_row(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1, 3);
        add_row(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1, 3);
        add_row(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1, 3);
        add_row(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1, 3);
        add_row(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1, 3);
        add_row(1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1, 3);
        add_row(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1, 3);
        add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 3, 3);
        // Back-pressure, queue and buffer fill up
        add_row(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4, 4);
        add_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3, 4);
        add_row(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2, 4);
        add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4, 4);
        // Pops that must be ignored
        add_row(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1, 5);
        add_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 3, 5);
        add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 2, 5);
        add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1, 5);
        add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1, 5);
        add_row(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1, 5);
        add_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1, 5);
        add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 2, 5);
        // Flush with pairs parked in the IF/ID buffer
        add_row(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4, 6);
        add_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1, 6);
        add_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1, 6);
        add_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1, 6);
        add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 3, 6);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pair  = '0;
        flush       = 1'b0;
        pop_1       = 1'b0;
        pop_2       = 1'b0;
        test_num    = 0;
        timeouts    = 0;
        lfsr_state  = 16'd28134;
        next_pc     = `FE_PC_BITS'(32'h0000_1000);
        build_table();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            for (int n = 0; n < rows[i].reps; n++) begin
                apply_row(rows[i]);
            end
        end
        drain_queue();
        // Let the checker report the last test
        @(negedge clk);
        test_num = 0;
        repeat (2) @(negedge clk);
        $display("Summary: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
